// File: Makefile
# Verilator build and run of the multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_mul_top
SEED      ?= 95270
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: simulate clean

# A failing check ends the run with $$fatal, so the exit status carries the result
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f project.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: mul_control.sv
//====================================================================
// Decode stage: FSM that walks the multiplier bits and issues the
// load, add and shift strobes, each with its decision taint
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_control (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        start_t,
    output logic        busy,
    mul_ctrl_if.ctrl    ctl
);

    localparam int unsigned BIT_W = $clog2(`MUL_WIDTH);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`MUL_WIDTH - 1);

    mul_pkg::ctl_state_e state;
    logic [BIT_W-1:0]    bit_idx;
    logic                decision_t;
    logic                cur_bit;
    logic                cur_bit_t;
    logic                strobe_t;

    // Multiplier bit under decision this cycle
    assign cur_bit   = ctl.multiplier_reg[bit_idx];
    assign cur_bit_t = ctl.multiplier_reg_t[bit_idx];

    //==================================================================
    // State register, bit counter, sticky decision taint
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= mul_pkg::IDLE;
            bit_idx    <= '0;
            decision_t <= 1'b0;
        end else begin
            case (state)
                mul_pkg::IDLE: begin
                    // A new operation starts with a fresh decision taint
                    if (start) begin
                        state      <= mul_pkg::LOAD;
                        bit_idx    <= '0;
                        decision_t <= start_t;
                    end
                end
                mul_pkg::LOAD: begin
                    state <= mul_pkg::ADD;
                end
                mul_pkg::ADD: begin
                    // The add or skip choice depended on this bit
                    state      <= mul_pkg::SHIFT;
                    decision_t <= decision_t | cur_bit_t;
                end
                mul_pkg::SHIFT: begin
                    if (bit_idx == LAST_BIT) begin
                        state <= mul_pkg::FINISH;
                    end else begin
                        state   <= mul_pkg::ADD;
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                mul_pkg::FINISH: begin
                    state <= mul_pkg::IDLE;
                end
                default: begin
                    state <= mul_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy = (state != mul_pkg::IDLE);

    //==================================================================
    // Strobe decode
    //==================================================================
    assign ctl.mrld    = (state == mul_pkg::LOAD);
    assign ctl.mdld    = (state == mul_pkg::LOAD);
    assign ctl.rsclear = (state == mul_pkg::LOAD);
    assign ctl.rsload  = (state == mul_pkg::ADD) & cur_bit;
    assign ctl.rsshr   = (state == mul_pkg::SHIFT);
    assign ctl.finish  = (state == mul_pkg::FINISH);

    // Taint of the ADD decision counts in the same cycle,
    // the sticky bit covers everything after it
    assign strobe_t = busy
                    & (decision_t | ((state == mul_pkg::ADD) & cur_bit_t));

    assign ctl.mrld_t    = strobe_t;
    assign ctl.mdld_t    = strobe_t;
    assign ctl.rsclear_t = strobe_t;
    assign ctl.rsload_t  = strobe_t;
    assign ctl.rsshr_t   = strobe_t;

endmodule

// File: mul_ctrl_if.sv
//====================================================================
// Controller to datapath bundle: strobes with their taint bits,
// finish for the result stage, multiplier register fed back
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

interface mul_ctrl_if;

    // Datapath strobes
    logic rsclear;
    logic rsload;
    logic rsshr;
    logic mrld;
    logic mdld;

    // Shadow taint of each strobe
    logic rsclear_t;
    logic rsload_t;
    logic rsshr_t;
    logic mrld_t;
    logic mdld_t;

    // Last cycle of an operation
    logic finish;

    // Multiplier register and its taint, read back by the FSM
    logic [`MUL_WIDTH-1:0] multiplier_reg;
    logic [`MUL_WIDTH-1:0] multiplier_reg_t;

    modport ctrl (
        output rsclear, rsload, rsshr, mrld, mdld,
        output rsclear_t, rsload_t, rsshr_t, mrld_t, mdld_t,
        output finish,
        input  multiplier_reg, multiplier_reg_t
    );

    modport dp (
        input  rsclear, rsload, rsshr, mrld, mdld,
        input  rsclear_t, rsload_t, rsshr_t, mrld_t, mdld_t,
        output multiplier_reg, multiplier_reg_t
    );

    modport res (
        input  finish
    );

endinterface

// File: mul_datapath.sv
//====================================================================
// Execute stage: operand registers and running sum, add and shift
// steps, and the shadow taint of every register bit
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MUL_WIDTH-1:0]     multiplier,
    input  logic [`MUL_WIDTH-1:0]     multiplier_t,
    input  logic [`MUL_WIDTH-1:0]     multiplicand,
    input  logic [`MUL_WIDTH-1:0]     multiplicand_t,
    mul_ctrl_if.dp                    dp,
    output logic [2*`MUL_WIDTH-1:0]   product,
    output logic [2*`MUL_WIDTH-1:0]   product_t
);

    localparam int W  = `MUL_WIDTH;
    localparam int SW = 2 * W + 1;

    logic [W-1:0]  mr_reg;
    logic [W-1:0]  mr_reg_t;
    logic [SW-1:0] md_reg;
    logic [SW-1:0] md_reg_t;
    logic [SW-1:0] rs_reg;
    logic [SW-1:0] rs_reg_t;

    logic [SW-1:0] sum;
    logic [SW-1:0] carry_t;
    logic [SW-1:0] md_strobe_mask;
    logic [SW-1:0] rs_strobe_mask;

    // Tainted strobes mark the low half of their target
    assign md_strobe_mask = {{(W + 1){1'b0}}, {W{dp.mdld_t}}};
    assign rs_strobe_mask = {{(W + 1){1'b0}},
                             {W{dp.rsclear_t | dp.rsload_t | dp.rsshr_t}}};

    assign sum = rs_reg + md_reg;

    //==================================================================
    // Carry chain taint
    //==================================================================
    // Ripple the carry bit by bit; a carry out of bit i is tainted
    // only if it happens and an operand bit i is tainted
    always_comb begin : carry_chain
        logic c;
        logic g;
        c       = 1'b0;
        carry_t = '0;
        for (int i = 0; i < SW - 1; i++) begin
            g = (md_reg[i] & rs_reg[i]) | (md_reg[i] & c) | (rs_reg[i] & c);
            carry_t[i + 1] = g & (md_reg_t[i] | rs_reg_t[i]);
            c = g;
        end
    end

    //==================================================================
    // Operand registers
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mr_reg   <= '0;
            mr_reg_t <= '0;
            md_reg   <= '0;
            md_reg_t <= '0;
        end else begin
            if (dp.mrld) begin
                mr_reg   <= multiplier;
                mr_reg_t <= multiplier_t | {W{dp.mrld_t}};
            end else begin
                mr_reg_t <= mr_reg_t | {W{dp.mrld_t}};
            end

            // Multiplicand sits in the upper half for the right-shift scheme
            if (dp.mdld) begin
                md_reg   <= {1'b0, multiplicand, {W{1'b0}}};
                md_reg_t <= {1'b0, multiplicand_t, {W{dp.mdld_t}}};
            end else begin
                md_reg_t <= md_reg_t | md_strobe_mask;
            end
        end
    end

    //==================================================================
    // Running sum
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_reg   <= '0;
            rs_reg_t <= '0;
        end else if (dp.rsclear) begin
            rs_reg   <= '0;
            rs_reg_t <= rs_strobe_mask;
        end else if (dp.rsload) begin
            rs_reg   <= sum;
            rs_reg_t <= rs_reg_t | md_reg_t | carry_t | rs_strobe_mask;
        end else if (dp.rsshr) begin
            // Taint moves with its data bit
            rs_reg   <= rs_reg >> 1;
            rs_reg_t <= (rs_reg_t >> 1) | rs_strobe_mask;
        end else begin
            rs_reg_t <= rs_reg_t | rs_strobe_mask;
        end
    end

    assign dp.multiplier_reg   = mr_reg;
    assign dp.multiplier_reg_t = mr_reg_t;

    assign product   = rs_reg[2*W-1:0];
    assign product_t = rs_reg_t[2*W-1:0];

endmodule

// File: mul_pkg.sv
//====================================================================
// Shared types for the multiplier stages and the bound checks
// Referenced by scoped name, never imported
//====================================================================
package mul_pkg;

    //==================================================================
    // Controller states
    //==================================================================
    // IDLE   waits for a start pulse
    // LOAD   loads operands and clears the running sum
    // ADD    adds the multiplicand when the current multiplier bit is set
    // SHIFT  shifts the running sum right by one
    // FINISH hands the product over to the result stage
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOAD   = 3'd1,
        ADD    = 3'd2,
        SHIFT  = 3'd3,
        FINISH = 3'd4
    } ctl_state_e;

endpackage

// File: mul_props.sv
//====================================================================
// Bound checks on the multiplier top: done timing, busy after reset
// and exclusive running-sum strobes
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_props (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input logic                busy,
    input logic                done,
    input logic                rsclear,
    input logic                rsload,
    input logic                rsshr,
    input mul_pkg::ctl_state_e state
);

    // done is set by edge 2W+2 after the start edge, sampled one edge later
    localparam int DONE_DELAY = 2 * `MUL_WIDTH + 3;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> ##DONE_DELAY done)
        else $error("done missing at the fixed latency after an accepted start");

    done_has_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start && !busy, DONE_DELAY))
        else $error("done without an accepted start at the fixed latency");

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rsclear, rsload, rsshr}))
        else $error("more than one running-sum strobe high");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!busy && !done && state == mul_pkg::IDLE))
        else $error("controller not idle after reset");

endmodule

// File: mul_result.sv
//====================================================================
// Result stage: holds the finished product and its taint, flags any
// taint in it, and pulses done for one cycle
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_result (
    input  logic                      clk,
    input  logic                      rst_n,
    mul_ctrl_if.res                   res,
    input  logic [2*`MUL_WIDTH-1:0]   product_in,
    input  logic [2*`MUL_WIDTH-1:0]   product_t_in,
    output logic [2*`MUL_WIDTH-1:0]   product,
    output logic [2*`MUL_WIDTH-1:0]   product_t,
    output logic                      product_tainted,
    output logic                      done
);

    // Capture on the edge that ends FINISH, hold until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product         <= '0;
            product_t       <= '0;
            product_tainted <= 1'b0;
        end else if (res.finish) begin
            product         <= product_in;
            product_t       <= product_t_in;
            product_tainted <= |product_t_in;
        end
    end

    // Done follows finish by one cycle, same edge as the capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= res.finish;
        end
    end

endmodule

// File: mul_settings.svh
//====================================================================
// Build-time settings for the shift-and-add multiplier
// Include wherever the operand width is needed
//====================================================================
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand width in bits, 2 or more
// Product is twice this, running sum adds one carry bit on top
`define MUL_WIDTH 8

`endif

// File: mul_top.sv
//====================================================================
// Multiplier top level: control, datapath and result stages joined
// by the strobe bundle, plain ports outside
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      start_t,
    input  logic [`MUL_WIDTH-1:0]     multiplier,
    input  logic [`MUL_WIDTH-1:0]     multiplier_t,
    input  logic [`MUL_WIDTH-1:0]     multiplicand,
    input  logic [`MUL_WIDTH-1:0]     multiplicand_t,
    output logic                      busy,
    output logic                      done,
    output logic [2*`MUL_WIDTH-1:0]   product,
    output logic [2*`MUL_WIDTH-1:0]   product_t,
    output logic                      product_tainted
);

    // Running product straight from the datapath
    logic [2*`MUL_WIDTH-1:0] dp_product;
    logic [2*`MUL_WIDTH-1:0] dp_product_t;

    mul_ctrl_if ctl_bus ();

    mul_control u_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .start_t (start_t),
        .busy    (busy),
        .ctl     (ctl_bus.ctrl)
    );

    mul_datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .multiplier     (multiplier),
        .multiplier_t   (multiplier_t),
        .multiplicand   (multiplicand),
        .multiplicand_t (multiplicand_t),
        .dp             (ctl_bus.dp),
        .product        (dp_product),
        .product_t      (dp_product_t)
    );

    mul_result u_result (
        .clk             (clk),
        .rst_n           (rst_n),
        .res             (ctl_bus.res),
        .product_in      (dp_product),
        .product_t_in    (dp_product_t),
        .product         (product),
        .product_t       (product_t),
        .product_tainted (product_tainted),
        .done            (done)
    );

endmodule

// File: project.f
+incdir+.
mul_pkg.sv
mul_ctrl_if.sv
mul_control.sv
mul_datapath.sv
mul_result.sv
mul_top.sv
tb_clock.sv
mul_props.sv
tb_mul_top.sv

// File: tb_clock.sv
//====================================================================
// Testbench clock and reset, 20 ns period, reset low for 10 cycles
//====================================================================
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb_mul_top.sv
//====================================================================
// Testbench for the taint-tracking multiplier: a table of operands
// and expected results run back to back, then a start-while-busy run
//====================================================================
`timescale 1ns/1ps
`include "mul_settings.svh"

module tb_mul_top #(
    parameter int SEED = 95270
);

    localparam int W          = `MUL_WIDTH;
    localparam int LATENCY    = 2 * W + 3;
    localparam int NUM_FIXED  = 9;
    localparam int NUM_RANDOM = 8;
    // Two extra slots for the start-while-busy run
    localparam int TIMEOUT_CYCLES = (NUM_FIXED + NUM_RANDOM + 2) * (2 * W + 6) + 50;

    typedef logic [W-1:0]   op_t;
    typedef logic [2*W-1:0] prod_t;

    typedef struct {
        string name;
        op_t   mr;
        op_t   mr_t;
        op_t   md;
        op_t   md_t;
        logic  st_t;
        prod_t exp_prod;
        op_t   exp_low_t;
        logic  exp_tainted;
    } entry_t;

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  start_t;
    op_t   multiplier;
    op_t   multiplier_t;
    op_t   multiplicand;
    op_t   multiplicand_t;
    logic  busy;
    logic  done;
    prod_t product;
    prod_t product_t;
    logic  product_tainted;

    entry_t table_q[$];
    int     seed = SEED;
    int     cycle_count = 0;

    tb_clock clock0 (.clk(clk), .rst_n(rst_n));

    mul_top dut0 (
        .clk(clk), .rst_n(rst_n), .start(start), .start_t(start_t),
        .multiplier(multiplier), .multiplier_t(multiplier_t),
        .multiplicand(multiplicand), .multiplicand_t(multiplicand_t),
        .busy(busy), .done(done), .product(product), .product_t(product_t),
        .product_tainted(product_tainted)
    );

    bind mul_top mul_props props0 (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done),
        .rsclear(ctl_bus.rsclear), .rsload(ctl_bus.rsload),
        .rsshr(ctl_bus.rsshr), .state(u_control.state)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    //==================================================================
    // Reference model
    //==================================================================
    task automatic add_entry(input string name, input op_t mr, input op_t mr_t,
                             input op_t md, input op_t md_t, input logic st_t);
        entry_t e;
        e.name     = name;
        e.mr       = mr;
        e.mr_t     = mr_t;
        e.md       = md;
        e.md_t     = md_t;
        e.st_t     = st_t;
        e.exp_prod = prod_t'(mr) * prod_t'(md);
        // Tainted start or multiplier bit marks the final shift strobe,
        // which fills the low half of the sum taint
        e.exp_low_t   = {W{st_t | (|mr_t)}};
        e.exp_tainted = |e.exp_low_t;
        table_q.push_back(e);
    endtask

    // Called on a falling edge, returns one falling edge later
    task automatic pulse_start(input op_t mr, input op_t mr_t, input op_t md,
                               input op_t md_t, input logic st_t);
        multiplier     = mr;
        multiplier_t   = mr_t;
        multiplicand   = md;
        multiplicand_t = md_t;
        start          = 1'b1;
        start_t        = st_t;
        @(negedge clk);
        start   = 1'b0;
        start_t = 1'b0;
    endtask

    task automatic wait_done(output int waited);
        waited = 1;
        while (!done) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic run_entry(input entry_t e);
        int waited;
        pulse_start(e.mr, e.mr_t, e.md, e.md_t, e.st_t);
        wait_done(waited);
        check_value({e.name, " latency"}, 64'(LATENCY), 64'(waited));
        check_value({e.name, " product"}, 64'(e.exp_prod), 64'(product));
        check_value({e.name, " low taint"}, 64'(e.exp_low_t), 64'(product_t[W-1:0]));
        check_value({e.name, " tainted"}, 64'(e.exp_tainted), 64'(product_tainted));
        if (!e.exp_tainted) begin
            check_value({e.name, " high taint"}, 64'd0, 64'(product_t[2*W-1:W]));
        end
    endtask

    task automatic check_busy_ignored();
        int  waited;
        op_t mr;
        op_t md;
        mr = op_t'('hB7);
        md = op_t'('h4D);
        pulse_start(mr, '0, md, '0, 1'b0);
        repeat (3) @(negedge clk);
        // Second start mid-operation with other operands and a taint
        pulse_start(op_t'('h11), '0, op_t'('h22), '0, 1'b1);
        wait_done(waited);
        check_value("busy_ignore latency", 64'(LATENCY), 64'(waited + 4));
        check_value("busy_ignore product", 64'(prod_t'(mr) * prod_t'(md)), 64'(product));
        check_value("busy_ignore tainted", 64'd0, 64'(product_tainted));
        repeat (LATENCY + 1) begin
            @(negedge clk);
            check_value("busy_ignore extra done", 64'd0, 64'(done));
        end
    endtask

    initial begin
        start          = 1'b0;
        start_t        = 1'b0;
        multiplier     = '0;
        multiplier_t   = '0;
        multiplicand   = '0;
        multiplicand_t = '0;

        add_entry("zero_by_zero", '0, '0, '0, '0, 1'b0);
        add_entry("one_by_one", op_t'(1), '0, op_t'(1), '0, 1'b0);
        add_entry("ones_by_ones", '1, '0, '1, '0, 1'b0);
        add_entry("ones_by_one", '1, '0, op_t'(1), '0, 1'b0);
        add_entry("tainted_md_zero_mr", '0, '0, '1, '1, 1'b0);
        add_entry("mr_bit0_tainted", op_t'('h37), op_t'(1), op_t'('h9C), '0, 1'b0);
        add_entry("mr_msb_tainted", op_t'('hC3), op_t'(1) << (W - 1), op_t'('h7E), '0, 1'b0);
        add_entry("mr_mid_tainted", op_t'('h5A), op_t'(1) << (W / 2), op_t'('hE4), '0, 1'b0);
        add_entry("start_tainted", op_t'('h2D), '0, op_t'('hF1), '0, 1'b1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_entry($sformatf("random_%0d", i), op_t'($random(seed)), '0,
                      op_t'($random(seed)), '0, 1'b0);
        end

        @(posedge rst_n);
        @(negedge clk);
        // Idle outputs before any start
        check_value("reset busy", 64'd0, 64'(busy));
        check_value("reset done", 64'd0, 64'(done));
        check_value("reset product", 64'd0, 64'(product));
        check_value("reset product_t", 64'd0, 64'(product_t));
        check_value("reset tainted", 64'd0, 64'(product_tainted));

        // Each start goes out on the falling edge that shows done
        foreach (table_q[k]) begin
            run_entry(table_q[k]);
        end
        check_busy_ignored();

        $display("Simulation passed");
        $finish;
    end

endmodule
